// File: hdl/maxpool_pkg.sv
package maxpool_pkg;

  //////////////////////////////
  // Data path types
  //////////////////////////////
  localparam int DATA_WIDTH = 32;

  typedef logic signed [DATA_WIDTH-1:0] elem_t;  // One pooled element
  typedef logic [15:0] count_t;                   // Window count and index

  //////////////////////////////
  // AXI4-Lite control bus
  //////////////////////////////
  localparam int AXIL_ADDR_WIDTH = 6;
  localparam int AXIL_DATA_WIDTH = 32;

  typedef logic [AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_WIDTH-1:0] axil_data_t;

  // Register map
  localparam axil_addr_t ADDR_CTRL    = 6'h00;  // Start, done, idle
  localparam axil_addr_t ADDR_IER     = 6'h04;  // Interrupt enable
  localparam axil_addr_t ADDR_WINDOWS = 6'h10;  // Windows per job

  // Bits inside ADDR_CTRL
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_DONE_BIT  = 1;
  localparam int CTRL_IDLE_BIT  = 2;

  //////////////////////////////
  // State encodings
  //////////////////////////////
  typedef enum logic [1:0] {WR_IDLE, WR_RESP} axil_wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_DATA} axil_rd_state_e;

  // Window engine states
  typedef enum logic [1:0] {POOL_IDLE, POOL_RUN, POOL_HOLD} pool_state_e;

endpackage

// File: hdl/maxpool_control_s_axi.sv
`timescale 1ns/1ps

module maxpool_control_s_axi (
  input  logic                    ap_clk,
  input  logic                    areset,
  // AXI4-Lite write channels
  input  logic                    awvalid,
  output logic                    awready,
  input  maxpool_pkg::axil_addr_t awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  maxpool_pkg::axil_data_t wdata,
  input  logic [3:0]              wstrb,
  output logic                    bvalid,
  input  logic                    bready,
  output logic [1:0]              bresp,
  // AXI4-Lite read channels
  input  logic                    arvalid,
  output logic                    arready,
  input  maxpool_pkg::axil_addr_t araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output maxpool_pkg::axil_data_t rdata,
  output logic [1:0]              rresp,
  // Job interface to the pool engine
  input  logic                    job_done,
  output logic                    job_start,
  output maxpool_pkg::count_t     job_windows,
  output logic                    interrupt
);

  maxpool_pkg::axil_wr_state_e wr_state;
  maxpool_pkg::axil_rd_state_e rd_state;
  logic                        wr_hs;       // AW and W taken together
  logic                        ar_hs;
  logic                        ctrl_rd;     // Read of the status register
  logic                        start_req;
  logic                        ap_start;
  logic                        ap_start_r;
  logic                        ap_done;     // Sticky until read
  logic                        ap_idle;
  logic                        ier;
  maxpool_pkg::axil_data_t     wmask;
  maxpool_pkg::axil_data_t     win_merged;
  maxpool_pkg::axil_data_t     ctrl_word;

  //////////////////////////////
  // Write channel
  //////////////////////////////
  assign wr_hs   = (wr_state == maxpool_pkg::WR_IDLE) && awvalid && wvalid;
  assign awready = wr_hs;                               // Both ready in the same cycle
  assign wready  = wr_hs;
  assign bvalid  = (wr_state == maxpool_pkg::WR_RESP);
  assign bresp   = 2'b00;                               // Always OKAY

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_state <= maxpool_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        maxpool_pkg::WR_IDLE: begin
          if (wr_hs) wr_state <= maxpool_pkg::WR_RESP;
        end
        maxpool_pkg::WR_RESP: begin
          if (bready) wr_state <= maxpool_pkg::WR_IDLE;  // Response taken
        end
        default: wr_state <= maxpool_pkg::WR_IDLE;
      endcase
    end
  end

  // Byte lanes from the strobes
  assign wmask      = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
  assign win_merged = ({16'b0, job_windows} & ~wmask) | (wdata & wmask);

  assign start_req = wr_hs && (awaddr == maxpool_pkg::ADDR_CTRL) && wstrb[0] &&
                     wdata[maxpool_pkg::CTRL_START_BIT];

  // Software registers
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ier         <= 1'b0;
      job_windows <= '0;
    end else if (wr_hs) begin
      if (awaddr == maxpool_pkg::ADDR_IER && wstrb[0]) ier <= wdata[0];
      if (awaddr == maxpool_pkg::ADDR_WINDOWS) begin
        job_windows <= win_merged[15:0];  // Only the low half is kept
      end
    end
  end

  //////////////////////////////
  // Start, done and idle
  //////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_start   <= 1'b0;
      ap_start_r <= 1'b0;
      job_start  <= 1'b0;
      ap_idle    <= 1'b1;
      ap_done    <= 1'b0;
    end else begin
      ap_start_r <= ap_start;
      job_start  <= ap_start & ~ap_start_r;  // Rising edge of ap_start

      // Start only from idle, a start while busy is dropped
      if (job_done) begin
        ap_start <= 1'b0;
      end else if (start_req && ap_idle && !ap_start) begin
        ap_start <= 1'b1;
      end

      if (job_done) ap_idle <= 1'b1;
      else if (job_start) ap_idle <= 1'b0;

      // Done wins over a clearing read in the same cycle
      if (job_done) ap_done <= 1'b1;
      else if (ctrl_rd) ap_done <= 1'b0;
    end
  end

  assign interrupt = ier & ap_done;

  //////////////////////////////
  // Read channel
  //////////////////////////////
  assign arready = (rd_state == maxpool_pkg::RD_IDLE);
  assign ar_hs   = arready && arvalid;
  assign rvalid  = (rd_state == maxpool_pkg::RD_DATA);
  assign rresp   = 2'b00;
  assign ctrl_rd = ar_hs && (araddr == maxpool_pkg::ADDR_CTRL);

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      rd_state <= maxpool_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        maxpool_pkg::RD_IDLE: begin
          if (ar_hs) rd_state <= maxpool_pkg::RD_DATA;
        end
        maxpool_pkg::RD_DATA: begin
          if (rready) rd_state <= maxpool_pkg::RD_IDLE;
        end
        default: rd_state <= maxpool_pkg::RD_IDLE;
      endcase
    end
  end

  // Status word as seen on the bus
  always_comb begin
    ctrl_word                               = '0;
    ctrl_word[maxpool_pkg::CTRL_START_BIT]  = ap_start;
    ctrl_word[maxpool_pkg::CTRL_DONE_BIT]   = ap_done;
    ctrl_word[maxpool_pkg::CTRL_IDLE_BIT]   = ap_idle;
  end

  // Read data captured at the address handshake
  always_ff @(posedge ap_clk) begin
    if (ar_hs) begin
      case (araddr)
        maxpool_pkg::ADDR_CTRL:    rdata <= ctrl_word;
        maxpool_pkg::ADDR_IER:     rdata <= {31'b0, ier};
        maxpool_pkg::ADDR_WINDOWS: rdata <= {16'b0, job_windows};
        default:                   rdata <= '0;  // Unmapped reads as zero
      endcase
    end
  end

endmodule

// File: hdl/maxpool_window.sv
`timescale 1ns/1ps

module maxpool_window #(
  parameter int POOL_SIZE = 4
) (
  input  logic                ap_clk,
  input  logic                areset,
  input  logic                job_start,
  input  maxpool_pkg::count_t job_windows,
  // Element stream in
  input  logic                in_tvalid,
  output logic                in_tready,
  input  maxpool_pkg::elem_t  in_tdata,
  // One maximum per window out
  output logic                pool_tvalid,
  input  logic                pool_tready,
  output maxpool_pkg::elem_t  pool_tdata,
  output logic                job_done
);

  localparam int CNT_W = (POOL_SIZE > 1) ? $clog2(POOL_SIZE) : 1;

  maxpool_pkg::pool_state_e state;
  logic [CNT_W-1:0]         elem_cnt;   // Position inside the window
  maxpool_pkg::count_t      win_cnt;    // Windows handed on so far
  maxpool_pkg::count_t      win_total;  // Latched at job start
  maxpool_pkg::elem_t       run_max;
  maxpool_pkg::elem_t       next_max;
  logic                     in_hs;
  logic                     last_elem;
  logic                     last_win;

  assign in_tready   = (state == maxpool_pkg::POOL_RUN);   // Stalls while a result waits
  assign in_hs       = in_tvalid && in_tready;
  assign last_elem   = (elem_cnt == CNT_W'(POOL_SIZE - 1));
  assign last_win    = (win_cnt == win_total - 16'd1);
  assign pool_tvalid = (state == maxpool_pkg::POOL_HOLD);
  assign pool_tdata  = run_max;

  // First element loads, later ones win only if larger (signed)
  assign next_max = (elem_cnt == '0 || in_tdata > run_max) ? in_tdata : run_max;

  //////////////////////////////
  // Control FSM
  //////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state    <= maxpool_pkg::POOL_IDLE;
      elem_cnt <= '0;
      win_cnt  <= '0;
      job_done <= 1'b0;
    end else begin
      job_done <= 1'b0;  // Single-cycle pulse
      case (state)
        maxpool_pkg::POOL_IDLE: begin
          if (job_start) begin
            elem_cnt <= '0;
            win_cnt  <= '0;
            if (job_windows == '0) job_done <= 1'b1;  // Empty job ends at once
            else state <= maxpool_pkg::POOL_RUN;
          end
        end
        maxpool_pkg::POOL_RUN: begin
          if (in_hs) begin
            if (last_elem) begin
              elem_cnt <= '0;
              state    <= maxpool_pkg::POOL_HOLD;   // Result is ready next cycle
            end else begin
              elem_cnt <= elem_cnt + 1'b1;
            end
          end
        end
        maxpool_pkg::POOL_HOLD: begin
          if (pool_tready) begin
            if (last_win) begin
              job_done <= 1'b1;
              state    <= maxpool_pkg::POOL_IDLE;
            end else begin
              win_cnt <= win_cnt + 16'd1;
              state   <= maxpool_pkg::POOL_RUN;
            end
          end
        end
        default: state <= maxpool_pkg::POOL_IDLE;
      endcase
    end
  end

  // Running maximum and job length
  always_ff @(posedge ap_clk) begin
    if (in_hs) run_max <= next_max;
    if (job_start && state == maxpool_pkg::POOL_IDLE) win_total <= job_windows;
  end

endmodule

// File: hdl/maxpool_out_fifo.sv
`timescale 1ns/1ps

module maxpool_out_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic               ap_clk,
  input  logic               areset,
  // Write side
  input  logic               pool_tvalid,
  output logic               pool_tready,
  input  maxpool_pkg::elem_t pool_tdata,
  // Read side
  output logic               out_tvalid,
  input  logic               out_tready,
  output maxpool_pkg::elem_t out_tdata
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  maxpool_pkg::elem_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W-1:0]   rd_ptr_nxt;
  logic [CNT_W-1:0]   count;      // Words held, head included
  logic               wr_en;
  logic               rd_en;

  assign pool_tready = (count != CNT_W'(FIFO_DEPTH));  // Not full
  assign out_tvalid  = (count != '0);
  assign wr_en       = pool_tvalid && pool_tready;
  assign rd_en       = out_tvalid && out_tready;
  assign rd_ptr_nxt  = rd_ptr + 1'b1;                  // Wraps, depth is a power of two

  // Pointers and occupancy
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr_nxt;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  //////////////////////////////
  // Storage and head register
  //////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (wr_en) mem[wr_ptr] <= pool_tdata;
    // Head takes the incoming word when it becomes the oldest one
    if (wr_en && (count == '0 || (rd_en && count == CNT_W'(1)))) begin
      out_tdata <= pool_tdata;
    end else if (rd_en) begin
      out_tdata <= mem[rd_ptr_nxt];
    end
  end

endmodule

// File: hdl/krnl_maxpool.sv
`timescale 1ns/1ps

module krnl_maxpool #(
  parameter int POOL_SIZE  = 4,   // 4 for 2x2, 9 for 3x3
  parameter int FIFO_DEPTH = 16
) (
  input  logic                    ap_clk,
  input  logic                    areset,
  // AXI4-Lite control
  input  logic                    s_axi_control_awvalid,
  output logic                    s_axi_control_awready,
  input  maxpool_pkg::axil_addr_t s_axi_control_awaddr,
  input  logic                    s_axi_control_wvalid,
  output logic                    s_axi_control_wready,
  input  maxpool_pkg::axil_data_t s_axi_control_wdata,
  input  logic [3:0]              s_axi_control_wstrb,
  output logic                    s_axi_control_bvalid,
  input  logic                    s_axi_control_bready,
  output logic [1:0]              s_axi_control_bresp,
  input  logic                    s_axi_control_arvalid,
  output logic                    s_axi_control_arready,
  input  maxpool_pkg::axil_addr_t s_axi_control_araddr,
  output logic                    s_axi_control_rvalid,
  input  logic                    s_axi_control_rready,
  output maxpool_pkg::axil_data_t s_axi_control_rdata,
  output logic [1:0]              s_axi_control_rresp,
  output logic                    interrupt,
  // Element stream in, maxima out
  input  logic                    in_tvalid,
  output logic                    in_tready,
  input  maxpool_pkg::elem_t      in_tdata,
  output logic                    out_tvalid,
  input  logic                    out_tready,
  output maxpool_pkg::elem_t      out_tdata
);

  logic                job_start;
  logic                job_done;
  maxpool_pkg::count_t job_windows;
  logic                pool_tvalid;
  logic                pool_tready;
  maxpool_pkg::elem_t  pool_tdata;

  //////////////////////////////
  // Control slave
  //////////////////////////////
  maxpool_control_s_axi u_control (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .awvalid     (s_axi_control_awvalid),
    .awready     (s_axi_control_awready),
    .awaddr      (s_axi_control_awaddr),
    .wvalid      (s_axi_control_wvalid),
    .wready      (s_axi_control_wready),
    .wdata       (s_axi_control_wdata),
    .wstrb       (s_axi_control_wstrb),
    .bvalid      (s_axi_control_bvalid),
    .bready      (s_axi_control_bready),
    .bresp       (s_axi_control_bresp),
    .arvalid     (s_axi_control_arvalid),
    .arready     (s_axi_control_arready),
    .araddr      (s_axi_control_araddr),
    .rvalid      (s_axi_control_rvalid),
    .rready      (s_axi_control_rready),
    .rdata       (s_axi_control_rdata),
    .rresp       (s_axi_control_rresp),
    .job_done    (job_done),
    .job_start   (job_start),
    .job_windows (job_windows),
    .interrupt   (interrupt)
  );

  // Window engine
  maxpool_window #(
    .POOL_SIZE (POOL_SIZE)
  ) u_window (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .job_start   (job_start),
    .job_windows (job_windows),
    .in_tvalid   (in_tvalid),
    .in_tready   (in_tready),
    .in_tdata    (in_tdata),
    .pool_tvalid (pool_tvalid),
    .pool_tready (pool_tready),
    .pool_tdata  (pool_tdata),
    .job_done    (job_done)
  );

  // Result buffer, full back-pressures the engine
  maxpool_out_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_out_fifo (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .pool_tvalid (pool_tvalid),
    .pool_tready (pool_tready),
    .pool_tdata  (pool_tdata),
    .out_tvalid  (out_tvalid),
    .out_tready  (out_tready),
    .out_tdata   (out_tdata)
  );

endmodule

// File: verification/tb_maxpool.sv
`timescale 1ns/1ps

module tb_maxpool;

  localparam int POOL_SIZE   = 4;                         // Same as the DUT default
  localparam int TOTAL_ELEMS = (4 + 7 + 20) * POOL_SIZE;  // Elements over all three jobs
  localparam int WATCHDOG    = TOTAL_ELEMS * 8 + 500;     // In clock cycles
  localparam int POLL_LIMIT  = 400;

  logic                    ap_clk;
  logic                    areset;
  logic                    s_axi_control_awvalid;
  logic                    s_axi_control_awready;
  maxpool_pkg::axil_addr_t s_axi_control_awaddr;
  logic                    s_axi_control_wvalid;
  logic                    s_axi_control_wready;
  maxpool_pkg::axil_data_t s_axi_control_wdata;
  logic [3:0]              s_axi_control_wstrb;
  logic                    s_axi_control_bvalid;
  logic                    s_axi_control_bready;
  logic [1:0]              s_axi_control_bresp;
  logic                    s_axi_control_arvalid;
  logic                    s_axi_control_arready;
  maxpool_pkg::axil_addr_t s_axi_control_araddr;
  logic                    s_axi_control_rvalid;
  logic                    s_axi_control_rready;
  maxpool_pkg::axil_data_t s_axi_control_rdata;
  logic [1:0]              s_axi_control_rresp;
  logic                    interrupt;
  logic                    in_tvalid;
  logic                    in_tready;
  maxpool_pkg::elem_t      in_tdata;
  logic                    out_tvalid;
  logic                    out_tready;
  maxpool_pkg::elem_t      out_tdata;

  maxpool_pkg::elem_t stim_q[$];   // Elements not yet on the input stream
  maxpool_pkg::elem_t exp_q[$];    // Expected maxima, oldest first
  int unsigned        mismatches;
  int unsigned        failures;
  logic               stall;       // Holds out_tready low
  logic               irq_allowed; // Low while IER is clear
  logic               in_hs_seen;

  krnl_maxpool dut (.*);

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;  // 100 ns period
  end

  //////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////
  function automatic maxpool_pkg::elem_t ref_window_max(input maxpool_pkg::elem_t win[$]);
    maxpool_pkg::elem_t best;
    best = win[0];
    for (int i = 1; i < win.size(); i++) begin
      if (win[i] > best) best = win[i];  // Signed compare
    end
    return best;
  endfunction

  task automatic check_elem(input string name, input maxpool_pkg::elem_t got,
                            input maxpool_pkg::elem_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input maxpool_pkg::axil_data_t got,
                           input maxpool_pkg::axil_data_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("%0t: %s", $time, msg);
  endtask

  //////////////////////////////
  // AXI4-Lite bus tasks
  //////////////////////////////
  task automatic axil_write(input maxpool_pkg::axil_addr_t addr,
                            input maxpool_pkg::axil_data_t data);
    int n;
    n = 0;
    @(posedge ap_clk);
    s_axi_control_awvalid <= 1'b1;
    s_axi_control_wvalid  <= 1'b1;
    s_axi_control_awaddr  <= addr;
    s_axi_control_wdata   <= data;
    s_axi_control_wstrb   <= 4'hf;  // Full word
    do begin
      @(negedge ap_clk);
      n++;
    end while (!(s_axi_control_awready && s_axi_control_wready) && n < POLL_LIMIT);
    if (!(s_axi_control_awready && s_axi_control_wready)) begin
      report_failure("AXI write address and data never accepted");
    end
    @(posedge ap_clk);                 // Handshake edge
    s_axi_control_awvalid <= 1'b0;
    s_axi_control_wvalid  <= 1'b0;
    s_axi_control_bready  <= 1'b1;
    n = 0;
    do begin
      @(negedge ap_clk);
      n++;
    end while (!s_axi_control_bvalid && n < POLL_LIMIT);
    if (!s_axi_control_bvalid) report_failure("AXI write response never arrived");
    else check_reg("s_axi_control_bresp", {30'b0, s_axi_control_bresp}, '0);  // OKAY
    @(posedge ap_clk);
    s_axi_control_bready <= 1'b0;
  endtask

  task automatic axil_read(input maxpool_pkg::axil_addr_t addr,
                           output maxpool_pkg::axil_data_t data);
    int n;
    n = 0;
    @(posedge ap_clk);
    s_axi_control_arvalid <= 1'b1;
    s_axi_control_araddr  <= addr;
    do begin
      @(negedge ap_clk);
      n++;
    end while (!s_axi_control_arready && n < POLL_LIMIT);
    if (!s_axi_control_arready) report_failure("AXI read address never accepted");
    @(posedge ap_clk);
    s_axi_control_arvalid <= 1'b0;
    s_axi_control_rready  <= 1'b1;
    n = 0;
    do begin
      @(negedge ap_clk);
      n++;
    end while (!s_axi_control_rvalid && n < POLL_LIMIT);
    if (!s_axi_control_rvalid) report_failure("AXI read data never arrived");
    else check_reg("s_axi_control_rresp", {30'b0, s_axi_control_rresp}, '0);  // OKAY
    data = s_axi_control_rdata;       // Stable mid-cycle
    @(posedge ap_clk);
    s_axi_control_rready <= 1'b0;
  endtask

  //////////////////////////////
  // Stimulus and job helpers
  //////////////////////////////
  // Kind 0 random, 1 all negative, 2 tied maximum
  task automatic add_window(input int kind);
    maxpool_pkg::elem_t win[$];
    maxpool_pkg::elem_t base;
    base = maxpool_pkg::elem_t'($urandom) >>> 4;  // Leaves room below for the offset
    for (int i = 0; i < POOL_SIZE; i++) begin
      case (kind)
        1:       win.push_back(maxpool_pkg::elem_t'({1'b1, 31'($urandom)}));
        2:       win.push_back((i % 2 == 0) ? base : base - 7);
        default: win.push_back(maxpool_pkg::elem_t'($urandom));
      endcase
    end
    foreach (win[i]) stim_q.push_back(win[i]);
    exp_q.push_back(ref_window_max(win));
  endtask

  // Polls status until done, the read that sees it also clears it
  task automatic wait_done();
    maxpool_pkg::axil_data_t word;
    int n;
    n = 0;
    word = '0;
    while (!word[maxpool_pkg::CTRL_DONE_BIT] && n < POLL_LIMIT) begin
      axil_read(maxpool_pkg::ADDR_CTRL, word);
      n++;
    end
    if (word[maxpool_pkg::CTRL_DONE_BIT]) check_reg("ctrl at done", word, 32'h6);
    else report_failure("job never reported done");
  endtask

  task automatic drain_outputs();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < POLL_LIMIT) begin
      @(negedge ap_clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      failures++;
      $display("%0t: %0d expected outputs never appeared", $time, exp_q.size());
    end
  endtask

  // Input stream with gaps, output ready with random low cycles
  initial begin
    forever begin
      @(negedge ap_clk);
      in_hs_seen = in_tvalid && in_tready;
      @(posedge ap_clk);
      out_tready <= !stall && ($urandom % 4 != 0);
      if (in_hs_seen || !in_tvalid) begin   // Valid holds until taken
        if (stim_q.size() != 0 && $urandom % 4 != 0) begin
          in_tvalid <= 1'b1;
          in_tdata  <= stim_q.pop_front();
        end else begin
          in_tvalid <= 1'b0;
        end
      end
    end
  end

  // Output checker, samples mid-cycle
  always @(negedge ap_clk) begin
    if (!areset && out_tvalid && out_tready) begin
      if (exp_q.size() == 0) report_failure("output appeared with no window left to match");
      else check_elem("out_tdata", out_tdata, exp_q.pop_front());
    end
    if (!areset && !irq_allowed && interrupt) report_failure("interrupt high while IER is clear");
  end

  initial begin
    repeat (WATCHDOG) @(posedge ap_clk);
    $display("Timeout after %0d cycles, window FSM in %s", WATCHDOG,
             dut.u_window.state.name());
    $display("Regression failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    maxpool_pkg::axil_data_t rd;
    int unsigned seed;
    int n;
    seed = $urandom(32'h551f);
    areset                = 1'b1;
    s_axi_control_awvalid = 1'b0;
    s_axi_control_awaddr  = '0;
    s_axi_control_wvalid  = 1'b0;
    s_axi_control_wdata   = '0;
    s_axi_control_wstrb   = '0;
    s_axi_control_bready  = 1'b0;
    s_axi_control_arvalid = 1'b0;
    s_axi_control_araddr  = '0;
    s_axi_control_rready  = 1'b0;
    in_tvalid             = 1'b0;
    in_tdata              = '0;
    out_tready            = 1'b0;
    stall                 = 1'b0;
    irq_allowed           = 1'b0;
    mismatches            = 0;
    failures              = 0;
    repeat (2) @(posedge ap_clk);
    areset <= 1'b0;

    axil_read(maxpool_pkg::ADDR_CTRL, rd);
    check_reg("ctrl after reset", rd, 32'h4);          // Idle only
    check_reg("interrupt", {31'b0, interrupt}, '0);

    // Job 1, interrupt enabled, mixed windows
    irq_allowed = 1'b1;
    axil_write(maxpool_pkg::ADDR_IER, 32'h1);
    axil_write(maxpool_pkg::ADDR_WINDOWS, 32'd4);
    add_window(0);
    add_window(1);
    add_window(2);
    add_window(0);
    axil_write(maxpool_pkg::ADDR_CTRL, 32'h1);
    n = 0;
    while (!interrupt && n < POLL_LIMIT) begin
      @(negedge ap_clk);
      n++;
    end
    if (!interrupt) report_failure("interrupt did not rise at the end of job 1");
    drain_outputs();
    axil_read(maxpool_pkg::ADDR_CTRL, rd);
    check_reg("ctrl after job 1", rd, 32'h6);          // Done and idle
    @(negedge ap_clk);
    check_reg("interrupt after status read", {31'b0, interrupt}, '0);
    axil_read(maxpool_pkg::ADDR_CTRL, rd);
    check_reg("ctrl second read", rd, 32'h4);

    // Job 2, interrupt off, extra start while busy
    axil_write(maxpool_pkg::ADDR_IER, 32'h0);
    irq_allowed = 1'b0;
    axil_write(maxpool_pkg::ADDR_WINDOWS, 32'd7);
    for (int w = 0; w < 7; w++) add_window(w % 3);
    axil_write(maxpool_pkg::ADDR_CTRL, 32'h1);
    axil_write(maxpool_pkg::ADDR_CTRL, 32'h1);        // Lands mid-job, dropped
    wait_done();
    drain_outputs();
    axil_read(maxpool_pkg::ADDR_CTRL, rd);
    check_reg("ctrl after job 2", rd, 32'h4);

    // Job 3, output held off long enough to fill the FIFO
    axil_write(maxpool_pkg::ADDR_WINDOWS, 32'd20);
    for (int w = 0; w < 20; w++) add_window(w % 3);
    stall <= 1'b1;
    axil_write(maxpool_pkg::ADDR_CTRL, 32'h1);
    repeat (200) @(posedge ap_clk);
    axil_read(maxpool_pkg::ADDR_CTRL, rd);
    check_reg("ctrl with output stalled", rd, 32'h1);  // Engine held by back-pressure
    stall <= 1'b0;
    wait_done();
    drain_outputs();
    repeat (4) @(posedge ap_clk);  // Room for a stray extra output

    $display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: files.f
hdl/maxpool_pkg.sv
hdl/maxpool_control_s_axi.sv
hdl/maxpool_window.sv
hdl/maxpool_out_fifo.sv
hdl/krnl_maxpool.sv
verification/tb_maxpool.sv

// File: Makefile
TOP = tb_maxpool

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
